// File: cpu_pkg.sv
package cpu_pkg;

  localparam int instr_w = 32;
  localparam int reg_addr_w = 5;

  // ADDI x0, x0, 0
  localparam logic [instr_w-1:0] nop_instr = 32'h0000_0013;

  typedef enum logic [6:0] {
    op_op     = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_e;

  // funct3 codes of the supported subset
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;

  // funct7 bit that turns ADD into SUB
  localparam int f7_sub_bit = 5;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    res_alu,
    res_load,
    res_pc4
  } result_src_e;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_mem,
    fwd_wb
  } fwd_sel_e;

  typedef enum logic [2:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_kind_e;

endpackage

// File: cpu_register_file.sv
`timescale 1ns/1ps

module cpu_register_file #(
  parameter int xlen = 32
) (
  input  logic                           clk,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                           rd_write,
  input  logic [xlen-1:0]                rd_data,
  output logic [xlen-1:0]                rs1_data,
  output logic [xlen-1:0]                rs2_data
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rd_write && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Write in the same cycle is seen by the read
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (rd_write && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (rd_write && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

  a_wdata_known: assert property (@(posedge clk) rd_write |-> !$isunknown(rd_data));

endmodule

// File: cpu_fetch.sv
`timescale 1ns/1ps

module cpu_fetch #(
  parameter int xlen = 32
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall_f,
  input  logic                        stall_d,
  input  logic                        flush_d,
  input  logic                        redirect,
  input  logic [xlen-1:0]             redirect_pc,
  input  logic [cpu_pkg::instr_w-1:0] instr_data,
  output logic [xlen-1:0]             instr_addr,
  output logic [cpu_pkg::instr_w-1:0] instr_d,
  output logic [xlen-1:0]             pc_d
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_next;

  // Always predict not-taken
  assign pc_next = redirect ? redirect_pc : pc + xlen'(4);
  assign instr_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!stall_f) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_d) begin
      instr_d <= cpu_pkg::nop_instr;
    end else if (!stall_d) begin
      instr_d <= instr_data;
      pc_d    <= pc;
    end
  end

endmodule

// File: cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode #(
  parameter int xlen = 32
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush_e,
  input  logic [cpu_pkg::instr_w-1:0]    instr_d,
  input  logic [xlen-1:0]                pc_d,
  input  logic [xlen-1:0]                rs1_data,
  input  logic [xlen-1:0]                rs2_data,
  output logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
  output logic                           valid_e,
  output cpu_pkg::alu_op_e               alu_op_e,
  output logic                           alu_src_imm_e,
  output cpu_pkg::result_src_e           result_src_e,
  output logic                           reg_write_e,
  output logic                           mem_write_e,
  output logic                           is_load_e,
  output logic                           branch_e,
  output logic                           branch_ne_e,
  output logic                           jump_e,
  output logic [cpu_pkg::reg_addr_w-1:0] rs1_e,
  output logic [cpu_pkg::reg_addr_w-1:0] rs2_e,
  output logic [cpu_pkg::reg_addr_w-1:0] rd_e,
  output logic [xlen-1:0]                rs1_val_e,
  output logic [xlen-1:0]                rs2_val_e,
  output logic [xlen-1:0]                imm_e,
  output logic [xlen-1:0]                pc_e
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic legal;
  logic arith_ok;
  logic alu_src_imm;
  logic reg_write;
  logic mem_write;
  logic is_load;
  logic branch;
  logic jump;
  cpu_pkg::alu_op_e alu_arith;
  cpu_pkg::alu_op_e alu_op;
  cpu_pkg::result_src_e result_src;
  cpu_pkg::imm_kind_e imm_kind;
  logic [cpu_pkg::instr_w-1:0] imm32;

  assign opcode = instr_d[6:0];
  assign funct3 = instr_d[14:12];
  assign rs1_addr = instr_d[19:15];
  assign rs2_addr = instr_d[24:20];

  // Shared by OP and OP-IMM; SUB only exists in OP
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      cpu_pkg::f3_add_sub: begin
        alu_arith = (opcode == cpu_pkg::op_op && instr_d[25 + cpu_pkg::f7_sub_bit]) ?
                    cpu_pkg::alu_sub : cpu_pkg::alu_add;
      end
      cpu_pkg::f3_slt: alu_arith = cpu_pkg::alu_slt;
      cpu_pkg::f3_xor: alu_arith = cpu_pkg::alu_xor;
      cpu_pkg::f3_or:  alu_arith = cpu_pkg::alu_or;
      cpu_pkg::f3_and: alu_arith = cpu_pkg::alu_and;
      default: begin
        alu_arith = cpu_pkg::alu_add;
        arith_ok  = 1'b0;
      end
    endcase
  end

  // Unknown encodings fall through as bubbles
  always_comb begin
    legal       = 1'b0;
    alu_op      = cpu_pkg::alu_add;
    alu_src_imm = 1'b1;
    result_src  = cpu_pkg::res_alu;
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    is_load     = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    imm_kind    = cpu_pkg::imm_i;
    case (opcode)
      cpu_pkg::op_op: begin
        legal       = arith_ok;
        alu_op      = alu_arith;
        alu_src_imm = 1'b0;
        reg_write   = arith_ok;
      end
      cpu_pkg::op_imm: begin
        legal     = arith_ok;
        alu_op    = alu_arith;
        reg_write = arith_ok;
      end
      cpu_pkg::op_lui: begin
        legal     = 1'b1;
        alu_op    = cpu_pkg::alu_pass_b;
        reg_write = 1'b1;
        imm_kind  = cpu_pkg::imm_u;
      end
      cpu_pkg::op_load: begin
        legal      = (funct3 == cpu_pkg::f3_word);
        result_src = cpu_pkg::res_load;
        reg_write  = legal;
        is_load    = legal;
      end
      cpu_pkg::op_store: begin
        legal     = (funct3 == cpu_pkg::f3_word);
        mem_write = legal;
        imm_kind  = cpu_pkg::imm_s;
      end
      cpu_pkg::op_branch: begin
        legal    = (funct3 == cpu_pkg::f3_beq || funct3 == cpu_pkg::f3_bne);
        branch   = legal;
        imm_kind = cpu_pkg::imm_b;
      end
      cpu_pkg::op_jal: begin
        legal      = 1'b1;
        result_src = cpu_pkg::res_pc4;
        reg_write  = 1'b1;
        jump       = 1'b1;
        imm_kind   = cpu_pkg::imm_j;
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    case (imm_kind)
      cpu_pkg::imm_s: imm32 = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
      cpu_pkg::imm_b: imm32 = {{19{instr_d[31]}}, instr_d[31], instr_d[7],
                               instr_d[30:25], instr_d[11:8], 1'b0};
      cpu_pkg::imm_u: imm32 = {instr_d[31:12], 12'b0};
      cpu_pkg::imm_j: imm32 = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12],
                               instr_d[20], instr_d[30:21], 1'b0};
      default:        imm32 = {{20{instr_d[31]}}, instr_d[31:20]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_e) begin
      valid_e     <= 1'b0;
      reg_write_e <= 1'b0;
      mem_write_e <= 1'b0;
      is_load_e   <= 1'b0;
      branch_e    <= 1'b0;
      jump_e      <= 1'b0;
    end else begin
      valid_e     <= legal;
      reg_write_e <= reg_write;
      mem_write_e <= mem_write;
      is_load_e   <= is_load;
      branch_e    <= branch;
      jump_e      <= jump;
    end
  end

  always_ff @(posedge clk) begin
    alu_op_e      <= alu_op;
    alu_src_imm_e <= alu_src_imm;
    result_src_e  <= result_src;
    branch_ne_e   <= (funct3 == cpu_pkg::f3_bne);
    rs1_e         <= rs1_addr;
    rs2_e         <= rs2_addr;
    rd_e          <= instr_d[11:7];
    rs1_val_e     <= rs1_data;
    rs2_val_e     <= rs2_data;
    imm_e         <= xlen'(signed'(imm32));
    pc_e          <= pc_d;
  end

  a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
    !(reg_write_e && mem_write_e));

endmodule

// File: cpu_hazard_unit.sv
`timescale 1ns/1ps

module cpu_hazard_unit (
  input  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs1_e,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs2_e,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd_e,
  input  logic                           is_load_e,
  input  logic                           valid_e,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd_m,
  input  logic                           reg_write_m,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd_w,
  input  logic                           reg_write_w,
  input  logic                           redirect,
  output cpu_pkg::fwd_sel_e              fwd_a,
  output cpu_pkg::fwd_sel_e              fwd_b,
  output logic                           stall_f,
  output logic                           stall_d,
  output logic                           flush_d,
  output logic                           flush_e
);

  logic load_use;

  // Youngest producer wins
  assign fwd_a = (reg_write_m && rd_m != '0 && rd_m == rs1_e) ? cpu_pkg::fwd_mem :
                 (reg_write_w && rd_w != '0 && rd_w == rs1_e) ? cpu_pkg::fwd_wb :
                 cpu_pkg::fwd_reg;
  assign fwd_b = (reg_write_m && rd_m != '0 && rd_m == rs2_e) ? cpu_pkg::fwd_mem :
                 (reg_write_w && rd_w != '0 && rd_w == rs2_e) ? cpu_pkg::fwd_wb :
                 cpu_pkg::fwd_reg;

  assign load_use = valid_e && is_load_e && rd_e != '0 &&
                    (rd_e == rs1_addr || rd_e == rs2_addr);

  assign stall_f = load_use;
  assign stall_d = load_use;
  assign flush_d = redirect;
  assign flush_e = load_use || redirect;

  // A load in execute never redirects, so a held decode is never a wrong-path slot
  always_comb begin
    if (!$isunknown({stall_d, redirect})) begin
      a_stall_redirect: assert (!(stall_d && redirect));
    end
  end

endmodule

// File: cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute #(
  parameter int xlen = 32
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid_e,
  input  cpu_pkg::alu_op_e               alu_op_e,
  input  logic                           alu_src_imm_e,
  input  cpu_pkg::result_src_e           result_src_e,
  input  logic                           reg_write_e,
  input  logic                           mem_write_e,
  input  logic                           branch_e,
  input  logic                           branch_ne_e,
  input  logic                           jump_e,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd_e,
  input  logic [xlen-1:0]                rs1_val_e,
  input  logic [xlen-1:0]                rs2_val_e,
  input  logic [xlen-1:0]                imm_e,
  input  logic [xlen-1:0]                pc_e,
  input  cpu_pkg::fwd_sel_e              fwd_a,
  input  cpu_pkg::fwd_sel_e              fwd_b,
  input  logic [xlen-1:0]                result_m,
  input  logic [xlen-1:0]                result_w,
  output logic                           redirect,
  output logic [xlen-1:0]                redirect_pc,
  output logic                           valid_m,
  output logic [cpu_pkg::reg_addr_w-1:0] rd_m,
  output logic                           reg_write_m,
  output logic                           mem_write_m,
  output cpu_pkg::result_src_e           result_src_m,
  output logic [xlen-1:0]                alu_result_m,
  output logic [xlen-1:0]                store_data_m,
  output logic [xlen-1:0]                pc_plus4_m
);

  logic [xlen-1:0] src_a;
  logic [xlen-1:0] rs2_fwd;
  logic [xlen-1:0] src_b;
  logic [xlen-1:0] alu_result;
  logic taken;

  always_comb begin
    case (fwd_a)
      cpu_pkg::fwd_mem: src_a = result_m;
      cpu_pkg::fwd_wb:  src_a = result_w;
      default:          src_a = rs1_val_e;
    endcase
    case (fwd_b)
      cpu_pkg::fwd_mem: rs2_fwd = result_m;
      cpu_pkg::fwd_wb:  rs2_fwd = result_w;
      default:          rs2_fwd = rs2_val_e;
    endcase
  end

  assign src_b = alu_src_imm_e ? imm_e : rs2_fwd;

  always_comb begin
    case (alu_op_e)
      cpu_pkg::alu_sub:    alu_result = src_a - src_b;
      cpu_pkg::alu_and:    alu_result = src_a & src_b;
      cpu_pkg::alu_or:     alu_result = src_a | src_b;
      cpu_pkg::alu_xor:    alu_result = src_a ^ src_b;
      cpu_pkg::alu_slt:    alu_result = xlen'($signed(src_a) < $signed(src_b));
      cpu_pkg::alu_pass_b: alu_result = src_b;
      default:             alu_result = src_a + src_b;
    endcase
  end

  // BNE inverts the equality test
  assign taken = jump_e || (branch_e && ((src_a == rs2_fwd) != branch_ne_e));
  assign redirect = valid_e && taken;
  assign redirect_pc = pc_e + imm_e;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_m     <= 1'b0;
      reg_write_m <= 1'b0;
      mem_write_m <= 1'b0;
    end else begin
      valid_m     <= valid_e;
      reg_write_m <= valid_e && reg_write_e;
      mem_write_m <= mem_write_e;
    end
  end

  always_ff @(posedge clk) begin
    rd_m         <= rd_e;
    result_src_m <= result_src_e;
    alu_result_m <= alu_result;
    store_data_m <= rs2_fwd;
    pc_plus4_m   <= pc_e + xlen'(4);
  end

endmodule

// File: cpu_mem_writeback.sv
`timescale 1ns/1ps

module cpu_mem_writeback #(
  parameter int xlen = 32
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid_m,
  input  logic [cpu_pkg::reg_addr_w-1:0] rd_m,
  input  logic                           reg_write_m,
  input  logic                           mem_write_m,
  input  cpu_pkg::result_src_e           result_src_m,
  input  logic [xlen-1:0]                alu_result_m,
  input  logic [xlen-1:0]                store_data_m,
  input  logic [xlen-1:0]                pc_plus4_m,
  input  logic [xlen-1:0]                data_rdata,
  output logic [xlen-1:0]                data_addr,
  output logic [xlen-1:0]                data_wdata,
  output logic                           data_write,
  output logic [xlen-1:0]                result_m,
  output logic [cpu_pkg::reg_addr_w-1:0] rd_w,
  output logic                           reg_write_w,
  output logic [xlen-1:0]                result_w
);

  assign data_addr  = alu_result_m;
  assign data_wdata = store_data_m;
  assign data_write = valid_m && mem_write_m;

  // Load data comes back in the same cycle
  always_comb begin
    case (result_src_m)
      cpu_pkg::res_load: result_m = data_rdata;
      cpu_pkg::res_pc4:  result_m = pc_plus4_m;
      default:           result_m = alu_result_m;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_w <= 1'b0;
    end else begin
      reg_write_w <= reg_write_m;
    end
  end

  always_ff @(posedge clk) begin
    rd_w     <= rd_m;
    result_w <= result_m;
  end

  a_write_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(data_write));

endmodule

// File: cpu.sv
`timescale 1ns/1ps

module cpu #(
  parameter int xlen = 32
) (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic [xlen-1:0]             instr_addr,
  input  logic [cpu_pkg::instr_w-1:0] instr_data,
  output logic [xlen-1:0]             data_addr,
  output logic [xlen-1:0]             data_wdata,
  output logic                        data_write,
  input  logic [xlen-1:0]             data_rdata
);

  logic stall_f, stall_d, flush_d, flush_e;
  logic redirect;
  logic [xlen-1:0] redirect_pc;
  cpu_pkg::fwd_sel_e fwd_a, fwd_b;

  logic [cpu_pkg::instr_w-1:0] instr_d;
  logic [xlen-1:0] pc_d, rs1_data, rs2_data;
  logic [cpu_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr;

  logic valid_e, alu_src_imm_e, reg_write_e, mem_write_e, is_load_e;
  logic branch_e, branch_ne_e, jump_e;
  cpu_pkg::alu_op_e alu_op_e;
  cpu_pkg::result_src_e result_src_e;
  logic [cpu_pkg::reg_addr_w-1:0] rs1_e, rs2_e, rd_e;
  logic [xlen-1:0] rs1_val_e, rs2_val_e, imm_e, pc_e;

  logic valid_m, reg_write_m, mem_write_m;
  cpu_pkg::result_src_e result_src_m;
  logic [cpu_pkg::reg_addr_w-1:0] rd_m, rd_w;
  logic [xlen-1:0] alu_result_m, store_data_m, pc_plus4_m, result_m, result_w;
  logic reg_write_w;

  cpu_fetch #(.xlen(xlen)) fetch (
    .clk, .rst_n, .stall_f, .stall_d, .flush_d, .redirect, .redirect_pc,
    .instr_data, .instr_addr, .instr_d, .pc_d
  );

  cpu_register_file #(.xlen(xlen)) reg_file (
    .clk, .rs1_addr, .rs2_addr, .rd_addr(rd_w), .rd_write(reg_write_w),
    .rd_data(result_w), .rs1_data, .rs2_data
  );

  cpu_decode #(.xlen(xlen)) decode (
    .clk, .rst_n, .flush_e, .instr_d, .pc_d, .rs1_data, .rs2_data, .rs1_addr, .rs2_addr,
    .valid_e, .alu_op_e, .alu_src_imm_e, .result_src_e, .reg_write_e, .mem_write_e,
    .is_load_e, .branch_e, .branch_ne_e, .jump_e, .rs1_e, .rs2_e, .rd_e,
    .rs1_val_e, .rs2_val_e, .imm_e, .pc_e
  );

  cpu_hazard_unit hazard_unit (
    .rs1_addr, .rs2_addr, .rs1_e, .rs2_e, .rd_e, .is_load_e, .valid_e,
    .rd_m, .reg_write_m, .rd_w, .reg_write_w, .redirect,
    .fwd_a, .fwd_b, .stall_f, .stall_d, .flush_d, .flush_e
  );

  cpu_execute #(.xlen(xlen)) execute (
    .clk, .rst_n, .valid_e, .alu_op_e, .alu_src_imm_e, .result_src_e, .reg_write_e,
    .mem_write_e, .branch_e, .branch_ne_e, .jump_e, .rd_e, .rs1_val_e, .rs2_val_e,
    .imm_e, .pc_e, .fwd_a, .fwd_b, .result_m, .result_w, .redirect, .redirect_pc,
    .valid_m, .rd_m, .reg_write_m, .mem_write_m, .result_src_m, .alu_result_m,
    .store_data_m, .pc_plus4_m
  );

  cpu_mem_writeback #(.xlen(xlen)) mem_writeback (
    .clk, .rst_n, .valid_m, .rd_m, .reg_write_m, .mem_write_m, .result_src_m,
    .alu_result_m, .store_data_m, .pc_plus4_m, .data_rdata, .data_addr, .data_wdata,
    .data_write, .result_m, .rd_w, .reg_write_w, .result_w
  );

endmodule

// File: tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len = 48;
localparam int store_count = 18;
localparam logic [6:0] opc_imm = 7'h13;
localparam logic [6:0] opc_load = 7'h03;
localparam logic [31:0] loop_addr = 32'h0000_00bc;

// Words the loads expect at word index 32 and 33
localparam logic [31:0] load_word_a = 32'h0000_1234;
localparam logic [31:0] load_word_b = 32'hcafe_0001;

// Each entry is {address, data} of one store in program order
localparam logic [63:0] expected_stores [store_count] = '{
  {32'h0000_0000, 32'h0000_0044},
  {32'h0000_0004, 32'hffff_ffda},
  {32'h0000_0008, 32'h0000_0005},
  {32'h0000_000c, 32'h0000_003f},
  {32'h0000_0010, 32'h0000_003a},
  {32'h0000_0014, 32'h0000_0001},
  {32'h0000_0018, 32'h0000_0000},
  {32'h0000_001c, 32'h0000_0030},
  {32'h0000_0020, 32'h0000_010f},
  {32'h0000_0024, 32'hffff_ffca},
  {32'h0000_0028, 32'h0000_0001},
  {32'h0000_002c, 32'habcd_e000},
  {32'h0000_0040, 32'h0000_0075},
  {32'h0000_0030, 32'h0000_1245},
  {32'h0000_0034, 32'hcafe_0001},
  {32'h0000_0038, 32'h0000_0088},
  {32'h0000_003c, 32'h0000_000f},
  {32'h0000_0044, 32'h0000_00b4}
};

logic [31:0] program_words [prog_len];

function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] i_type(logic [6:0] opc, int f3, int rd, int rs1, int imm);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

// Word store only
function automatic logic [31:0] s_type(int rs2, int rs1, int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int imm);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] u_type(int rd, int imm);
  return {imm[19:0], rd[4:0], 7'h37};
endfunction

function automatic logic [31:0] j_type(int rd, int imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

task automatic build_program();
  program_words[0]  = i_type(opc_imm, 0, 1, 0, 'h35);
  program_words[1]  = i_type(opc_imm, 0, 2, 0, 'h0f);
  program_words[2]  = r_type(0, 0, 3, 1, 2);
  program_words[3]  = s_type(3, 0, 'h00);
  program_words[4]  = r_type('h20, 0, 4, 2, 1);
  program_words[5]  = s_type(4, 0, 'h04);
  program_words[6]  = r_type(0, 7, 5, 1, 2);
  program_words[7]  = s_type(5, 0, 'h08);
  program_words[8]  = r_type(0, 6, 6, 1, 2);
  program_words[9]  = r_type(0, 4, 7, 1, 2);
  // Store data two instructions behind its producer
  program_words[10] = s_type(6, 0, 'h0c);
  program_words[11] = s_type(7, 0, 'h10);
  program_words[12] = r_type(0, 2, 8, 4, 1);
  program_words[13] = r_type(0, 2, 9, 1, 4);
  program_words[14] = s_type(8, 0, 'h14);
  program_words[15] = s_type(9, 0, 'h18);
  program_words[16] = i_type(opc_imm, 7, 10, 1, 'h70);
  program_words[17] = s_type(10, 0, 'h1c);
  program_words[18] = i_type(opc_imm, 6, 11, 2, 'h100);
  program_words[19] = s_type(11, 0, 'h20);
  program_words[20] = i_type(opc_imm, 4, 12, 1, -1);
  program_words[21] = s_type(12, 0, 'h24);
  program_words[22] = i_type(opc_imm, 2, 13, 4, -37);
  program_words[23] = s_type(13, 0, 'h28);
  program_words[24] = u_type(14, 'habcde);
  program_words[25] = s_type(14, 0, 'h2c);
  // Dependent chain with store base from writeback and data from memory stage
  program_words[26] = i_type(opc_imm, 0, 15, 0, 'h30);
  program_words[27] = i_type(opc_imm, 0, 15, 15, 'h10);
  program_words[28] = r_type(0, 0, 16, 15, 1);
  program_words[29] = s_type(16, 15, 'h00);
  // Load-use pairs
  program_words[30] = i_type(opc_load, 2, 17, 0, 'h80);
  program_words[31] = i_type(opc_imm, 0, 18, 17, 'h11);
  program_words[32] = s_type(18, 0, 'h30);
  program_words[33] = i_type(opc_load, 2, 19, 0, 'h84);
  program_words[34] = s_type(19, 0, 'h34);
  program_words[35] = i_type(opc_load, 2, 20, 0, 'h00);
  program_words[36] = r_type(0, 0, 20, 20, 20);
  program_words[37] = s_type(20, 0, 'h38);
  // Taken BEQ skips two stores
  program_words[38] = i_type(opc_imm, 0, 21, 0, 'h35);
  program_words[39] = b_type(0, 21, 1, 12);
  program_words[40] = s_type(1, 0, 'h3c);
  program_words[41] = s_type(2, 0, 'h3c);
  program_words[42] = b_type(1, 1, 1, 8);
  program_words[43] = s_type(2, 0, 'h3c);
  program_words[44] = j_type(22, 8);
  program_words[45] = s_type(1, 0, 'h44);
  program_words[46] = s_type(22, 0, 'h44);
  program_words[47] = j_type(0, 0);
endtask

`endif

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

  localparam int clk_half = 20;
  localparam int reset_cycles = 16;
  localparam int drive_delay = 1;
  localparam int store_timeout = 50;
  localparam int idle_cycles = 60;
  localparam logic [31:0] seed = 32'h6f9d_69a4;
  localparam logic [31:0] nop_word = 32'h0000_0013;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_addr;
  logic [31:0] instr_data;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_write;
  logic [31:0] data_rdata;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:63];
  int pass_count;
  int fail_count;

  `include "tb_program.svh"

  cpu #(.xlen(32)) dut (
    .clk, .rst_n, .instr_addr, .instr_data, .data_addr, .data_wdata, .data_write,
    .data_rdata
  );

  always #(clk_half) clk = ~clk;

  // Both memories answer in the same cycle
  assign instr_data = (instr_addr[31:8] == 24'h0) ? imem[instr_addr[7:2]] : nop_word;
  assign data_rdata = dmem[data_addr[7:2]];

  always @(posedge clk) begin
    if (data_write) begin
      dmem[data_addr[7:2]] <= data_wdata;
    end
  end

  task automatic record_result(input string name, input int errors);
    if (errors == 0) begin
      pass_count++;
      $display("test %-9s ok", name);
    end else begin
      fail_count++;
      $display("test %-9s FAIL", name);
    end
  endtask

  // Reset window plus the first cycle after release
  task automatic observe_reset();
    int c;
    int errors;
    errors = 0;
    for (c = 0; c < reset_cycles; c++) begin
      @(posedge clk);
      #(drive_delay);
      if (c == reset_cycles - 1) begin
        rst_n = 1'b1;
      end
      @(negedge clk);
      if (data_write !== 1'b0 || instr_addr !== 32'h0) begin
        $display("ERR %0t: cycle %0d expected data_write 0 instr_addr 0, got %b %h",
                 $time, c, data_write, instr_addr);
        errors++;
      end
    end
    record_result("reset", errors);
  endtask

  task automatic compare_stores();
    int n;
    int waited;
    int errors;
    logic found;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    for (n = 0; n < store_count; n++) begin
      exp_addr = expected_stores[n][63:32];
      exp_data = expected_stores[n][31:0];
      waited = 0;
      found = 1'b0;
      while (!found && waited < store_timeout) begin
        @(negedge clk);
        waited++;
        found = (data_write === 1'b1);
      end
      if (!found) begin
        $display("store %0d did not appear on the data bus within %0d cycles",
                 n + 1, store_timeout);
        record_result($sformatf("store %0d", n + 1), 1);
        break;
      end
      errors = 0;
      if (data_addr !== exp_addr) begin
        $display("ERR %0t: store %0d address expected %h got %h",
                 $time, n + 1, exp_addr, data_addr);
        errors++;
      end
      if (data_wdata !== exp_data) begin
        $display("ERR %0t: store %0d data expected %h got %h",
                 $time, n + 1, exp_data, data_wdata);
        errors++;
      end
      record_result($sformatf("store %0d", n + 1), errors);
    end
  endtask

  // Nothing more may be stored once the core spins in its final loop
  task automatic confirm_idle();
    int c;
    int errors;
    int loop_hits;
    errors = 0;
    loop_hits = 0;
    for (c = 0; c < idle_cycles; c++) begin
      @(negedge clk);
      if (data_write === 1'b1) begin
        $display("ERR %0t: extra store expected none, got address %h data %h",
                 $time, data_addr, data_wdata);
        errors++;
      end
      if (instr_addr === loop_addr) begin
        loop_hits++;
      end
    end
    if (loop_hits == 0) begin
      $display("fetch never reached the final self-loop at %h", loop_addr);
      errors++;
    end
    record_result("idle", errors);
  endtask

  initial begin
    int i;
    clk = 1'b0;
    rst_n = 1'b0;
    pass_count = 0;
    fail_count = 0;
    void'($urandom(seed));
    build_program();
    for (i = 0; i < 64; i++) begin
      imem[i] = nop_word;
      dmem[i] = $urandom();
    end
    for (i = 0; i < prog_len; i++) begin
      imem[i] = program_words[i];
    end
    dmem[32] = load_word_a;
    dmem[33] = load_word_b;

    observe_reset();
    compare_stores();
    confirm_idle();

    $display("summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+.
cpu_pkg.sv
cpu_register_file.sv
cpu_fetch.sv
cpu_decode.sv
cpu_hazard_unit.sv
cpu_execute.sv
cpu_mem_writeback.sv
cpu.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
